//--- Makefile
TOP = kv_tb

.PHONY: help test clean

help:
	@echo "make test   build the key vault testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build output"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- kv_apb_decode.sv
`timescale 1ns/100ps

module kv_apb_decode import kv_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,

    // apb slave
    input  kv_addr_t paddr_i,
    input  logic     psel_i,
    input  logic     penable_i,
    input  logic     pwrite_i,
    input  kv_data_t pwdata_i,
    output logic     pready_o,
    output kv_data_t prdata_o,
    output logic     pslverr_o,

    // register request towards the store
    kv_req_if.dec    req
);

    kv_dec_state_t state_q;
    kv_dec_state_t state_d;

    logic     setup_phase;

    // transfer captured in the setup phase
    kv_addr_t addr_q;
    kv_data_t wdata_q;
    logic     write_q;

    // registered response
    kv_data_t prdata_q;
    logic     pslverr_q;

    assign setup_phase = psel_i & ~penable_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (setup_phase) begin
                    state_d = EXEC;
                end
            end
            EXEC:    state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && setup_phase) begin
            addr_q  <= paddr_i;
            wdata_q <= pwdata_i;
            write_q <= pwrite_i;
        end
    end

    // sample the store response at the end of the request cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end else if (state_q == EXEC) begin
            prdata_q  <= write_q ? '0 : req.rdata;
            pslverr_q <= req.err;
        end else if (state_q == DONE) begin
            // error only qualifies the completing cycle
            pslverr_q <= 1'b0;
        end
    end

    assign req.req   = (state_q == EXEC);
    assign req.write = write_q;
    assign req.addr  = addr_q;
    assign req.wdata = wdata_q;

    assign pready_o  = (state_q == DONE);
    assign prdata_o  = prdata_q;
    assign pslverr_o = pslverr_q;

    // master never enters an access phase without select
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (rst_i) penable_i |-> psel_i);

    // one completion pulse per transfer
    a_pready_single: assert property (
        @(posedge clk) disable iff (rst_i) pready_o |=> !pready_o);

endmodule

//--- kv_golden.txt
# W name addr wdata slverr | R name addr rdata slverr | P name client entry offset rdata
# H name client entry offset wdata mask | C name entry offset wdata0 wdata1 mask
R rst_ctrl7 1c 00000000 0
H mask_wr 0 1 0 a5a50001 1
P mask_c0 0 1 0 a5a50001
P mask_c1 1 1 0 00000000
R mask_rb 04 00000010 0
C tie_wr 2 3 11112222 33334444 3
P tie_c0 0 2 3 11112222
P tie_c1 1 2 3 11112222
R tie_rb 08 00000030 0
H use_wr 1 3 2 deadbeef 3
P use_pre 1 3 2 deadbeef
W use_lock 0c 00000002 0
P use_c0 0 3 2 00000000
W use_unset 0c 00000000 0
R use_rb 0c 00000032 0
H wl_init 0 4 1 cafef00d 1
W wl_lock 10 00000001 0
H wl_hw 1 4 1 12345678 3
W wl_clear 10 00000004 0
P wl_keep 0 4 1 cafef00d
R wl_rb 10 00000011 0
H clr_init 0 5 0 0badc0de 3
W clr_cmd 14 00000004 0
R clr_rb 14 00000000 0
H clr_re 1 5 1 00000777 1
P clr_old 0 5 0 00000000
W err_data_wr 44 ffffffff 1
R err_data_rd 40 00000000 1
R err_hole 20 00000000 1
W err_unmap_wr fc 00000007 1
R err_unmap_rd c0 00000000 1
P err_keep 0 1 0 a5a50001
R err_ctrl_keep 04 00000010 0

//--- kv_pkg.sv
package kv_pkg;

    // vault geometry
    localparam int KV_NUM_KEYS    = 8;
    localparam int KV_NUM_DWORDS  = 4;
    // width of the dest_valid mask, upper bound on read clients
    localparam int KV_MAX_CLIENTS = 4;

    typedef logic [$clog2(KV_NUM_KEYS)-1:0]   kv_entry_t;
    typedef logic [$clog2(KV_NUM_DWORDS)-1:0] kv_offset_t;
    typedef logic [31:0]                      kv_data_t;
    typedef logic [7:0]                       kv_addr_t;
    typedef logic [KV_MAX_CLIENTS-1:0]        kv_mask_t;

    // control register n at KV_CTRL_BASE + 4*n
    localparam kv_addr_t KV_CTRL_BASE = 8'h00;

    // key data region, never reachable from software
    localparam kv_addr_t KV_DATA_BASE = 8'h40;
    localparam kv_addr_t KV_DATA_END  =
        kv_addr_t'(int'(KV_DATA_BASE) + KV_NUM_KEYS * KV_NUM_DWORDS * 4 - 1);

    // control register fields
    localparam int KV_LOCK_WR_BIT  = 0;
    localparam int KV_LOCK_USE_BIT = 1;
    localparam int KV_CLEAR_BIT    = 2;
    localparam int KV_DEST_LSB     = 4;

    // apb decoder states
    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        DONE
    } kv_dec_state_t;

endpackage

//--- kv_read_mux.sv
`timescale 1ns/100ps

module kv_read_mux import kv_pkg::*; #(
    parameter int NUM_READ = 2
) (
    input  kv_data_t   [KV_NUM_KEYS-1:0][KV_NUM_DWORDS-1:0] key_data_i,
    input  logic       [KV_NUM_KEYS-1:0]                  lock_use_i,
    input  kv_mask_t   [KV_NUM_KEYS-1:0]                  dest_valid_i,
    input  kv_entry_t  [NUM_READ-1:0]                     rd_entry_i,
    input  kv_offset_t [NUM_READ-1:0]                     rd_offset_i,
    output kv_data_t   [NUM_READ-1:0]                     rd_data_o
);

    // each client owns one bit of dest_valid
    if (NUM_READ > KV_MAX_CLIENTS) begin : g_cfg_chk
        $error("kv_read_mux: NUM_READ exceeds the dest_valid mask width");
    end

    // and-or mux over every entry and dword
    always_comb begin
        logic sel;

        for (int c = 0; c < NUM_READ; c++) begin
            rd_data_o[c] = '0;
            for (int e = 0; e < KV_NUM_KEYS; e++) begin
                for (int d = 0; d < KV_NUM_DWORDS; d++) begin
                    // entry must be usable and granted to this client
                    sel = (rd_entry_i[c] == kv_entry_t'(e)) &&
                          (rd_offset_i[c] == kv_offset_t'(d)) &&
                          !lock_use_i[e] && dest_valid_i[e][c];
                    rd_data_o[c] = rd_data_o[c] | ({$bits(kv_data_t){sel}} & key_data_i[e][d]);
                end
            end
            // a use-locked entry must never leak through any client port
            a_lock_use_zero: assert (!lock_use_i[rd_entry_i[c]] || rd_data_o[c] == '0)
                else $error("kv_read_mux: client %0d read a use-locked entry", c);
        end
    end

endmodule

//--- kv_req_if.sv
`timescale 1ns/100ps

// single register request from the apb decoder to the vault storage
interface kv_req_if import kv_pkg::*; ();

    // one-cycle request strobe
    logic     req;
    logic     write;
    kv_addr_t addr;
    kv_data_t wdata;

    // combinational response, valid while req is high
    kv_data_t rdata;
    logic     err;

    modport dec (
        output req,
        output write,
        output addr,
        output wdata,
        input  rdata,
        input  err
    );

    modport store (
        input  req,
        input  write,
        input  addr,
        input  wdata,
        output rdata,
        output err
    );

endinterface

//--- kv_store.sv
`timescale 1ns/100ps

module kv_store import kv_pkg::*; #(
    parameter int NUM_READ  = 2,
    parameter int NUM_WRITE = 2
) (
    input  logic                                          clk,
    input  logic                                          rst_i,
    kv_req_if.store                                       req,

    // hardware write ports
    input  logic       [NUM_WRITE-1:0]                    wr_vld_i,
    input  kv_entry_t  [NUM_WRITE-1:0]                    wr_entry_i,
    input  kv_offset_t [NUM_WRITE-1:0]                    wr_offset_i,
    input  kv_data_t   [NUM_WRITE-1:0]                    wr_data_i,
    input  kv_mask_t   [NUM_WRITE-1:0]                    wr_dest_valid_i,

    // state towards the read mux
    output kv_data_t   [KV_NUM_KEYS-1:0][KV_NUM_DWORDS-1:0] key_data_o,
    output logic       [KV_NUM_KEYS-1:0]                  lock_use_o,
    output kv_mask_t   [KV_NUM_KEYS-1:0]                  dest_valid_o
);

    // mask bits beyond the existing read clients are never stored
    localparam kv_mask_t READ_MASK = kv_mask_t'((1 << NUM_READ) - 1);

    kv_data_t   [KV_NUM_KEYS-1:0][KV_NUM_DWORDS-1:0] key_q;
    logic       [KV_NUM_KEYS-1:0]                  lock_wr_q;
    logic       [KV_NUM_KEYS-1:0]                  lock_use_q;
    kv_mask_t   [KV_NUM_KEYS-1:0]                  dest_q;

    // winning hardware write per entry
    logic       [KV_NUM_KEYS-1:0]                  hw_we;
    kv_offset_t [KV_NUM_KEYS-1:0]                  hw_off;
    kv_data_t   [KV_NUM_KEYS-1:0]                  hw_data;
    kv_mask_t   [KV_NUM_KEYS-1:0]                  hw_mask;

    // software register decode
    kv_addr_t                                      ctrl_off;
    logic                                          ctrl_hit;
    logic                                          data_hit;
    kv_entry_t                                     sw_entry;
    logic                                          sw_we;
    logic       [KV_NUM_KEYS-1:0]                  sw_sel;
    logic       [KV_NUM_KEYS-1:0]                  clr;

    assign ctrl_off = req.addr - KV_CTRL_BASE;
    assign ctrl_hit = ctrl_off < kv_addr_t'(4 * KV_NUM_KEYS);
    assign data_hit = (req.addr >= KV_DATA_BASE) && (req.addr <= KV_DATA_END);
    assign sw_entry = kv_entry_t'(ctrl_off >> 2);
    assign sw_we    = req.req & req.write & ctrl_hit;

    // key data region and holes both fault
    assign req.err  = data_hit | ~ctrl_hit;

    always_comb begin
        for (int e = 0; e < KV_NUM_KEYS; e++) begin
            sw_sel[e] = sw_we && (sw_entry == kv_entry_t'(e));
            clr[e]    = sw_sel[e] & req.wdata[KV_CLEAR_BIT];
        end
    end

    // walk clients from high to low so the lowest index lands last
    always_comb begin
        for (int e = 0; e < KV_NUM_KEYS; e++) begin
            hw_we[e]   = 1'b0;
            hw_off[e]  = '0;
            hw_data[e] = '0;
            hw_mask[e] = '0;
            for (int c = NUM_WRITE - 1; c >= 0; c--) begin
                if (wr_vld_i[c] && wr_entry_i[c] == kv_entry_t'(e)) begin
                    hw_we[e]   = 1'b1;
                    hw_off[e]  = wr_offset_i[c];
                    hw_data[e] = wr_data_i[c];
                    hw_mask[e] = wr_dest_valid_i[c];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            key_q      <= '0;
            lock_wr_q  <= '0;
            lock_use_q <= '0;
            dest_q     <= '0;
        end else begin
            for (int e = 0; e < KV_NUM_KEYS; e++) begin
                // locks can only be set
                if (sw_sel[e]) begin
                    lock_wr_q[e]  <= lock_wr_q[e] | req.wdata[KV_LOCK_WR_BIT];
                    lock_use_q[e] <= lock_use_q[e] | req.wdata[KV_LOCK_USE_BIT];
                end
                // clear takes priority over a hardware write in the same cycle
                if (!lock_wr_q[e]) begin
                    if (clr[e]) begin
                        key_q[e]  <= '0;
                        dest_q[e] <= '0;
                    end else if (hw_we[e]) begin
                        key_q[e][hw_off[e]] <= hw_data[e];
                        dest_q[e]           <= hw_mask[e] & READ_MASK;
                    end
                end
            end
        end
    end

    // control register readback, clear always reads 0
    always_comb begin
        req.rdata = '0;
        if (ctrl_hit) begin
            req.rdata[KV_LOCK_WR_BIT]                = lock_wr_q[sw_entry];
            req.rdata[KV_LOCK_USE_BIT]               = lock_use_q[sw_entry];
            req.rdata[KV_DEST_LSB +: KV_MAX_CLIENTS] = dest_q[sw_entry];
        end
    end

    assign key_data_o   = key_q;
    assign lock_use_o   = lock_use_q;
    assign dest_valid_o = dest_q;

    for (genvar e = 0; e < KV_NUM_KEYS; e++) begin : g_lock_chk
        // neither hardware writes nor clear reach a write-locked entry
        a_locked_stable: assert property (
            @(posedge clk) lock_wr_q[e] && !rst_i |=> $stable(key_q[e]));
    end

    a_locks_sticky: assert property (
        @(posedge clk) !rst_i |=> (($past(lock_wr_q) & ~lock_wr_q) == '0) &&
                                  (($past(lock_use_q) & ~lock_use_q) == '0));

endmodule

//--- kv_tb.sv
`timescale 1ns/100ps

module kv_tb import kv_pkg::*; ();

    localparam int NUM_READ  = 2;
    localparam int NUM_WRITE = 2;

    typedef logic [$clog2(NUM_WRITE)-1:0] client_t;
    typedef logic [$clog2(NUM_READ)-1:0]  rd_client_t;

    logic                         clk = 1'b0;
    logic                         rst_i;
    kv_addr_t                     paddr_i;
    logic                         psel_i;
    logic                         penable_i;
    logic                         pwrite_i;
    kv_data_t                     pwdata_i;
    logic                         pready_o;
    logic                         pslverr_o;
    kv_data_t                     prdata_o;
    logic       [NUM_WRITE-1:0]   wr_vld_i;
    kv_entry_t  [NUM_WRITE-1:0]   wr_entry_i;
    kv_offset_t [NUM_WRITE-1:0]   wr_offset_i;
    kv_data_t   [NUM_WRITE-1:0]   wr_data_i;
    kv_mask_t   [NUM_WRITE-1:0]   wr_dest_valid_i;
    kv_entry_t  [NUM_READ-1:0]    rd_entry_i;
    kv_offset_t [NUM_READ-1:0]    rd_offset_i;
    kv_data_t   [NUM_READ-1:0]    rd_data_o;

    // parsed golden operations
    string                        op_q[$];
    string                        name_q[$];
    logic       [4:0][31:0]       fld_q[$];

    int                           checks = 0;
    int                           cycles = 0;
    int                           cycle_limit = 0;
    int unsigned                  lcg_state = 81;

    kv_top #(
        .NUM_READ  (NUM_READ),
        .NUM_WRITE (NUM_WRITE)
    ) DUT (
        .clk             (clk),
        .rst_i           (rst_i),
        .paddr_i         (paddr_i),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .pwdata_i        (pwdata_i),
        .pready_o        (pready_o),
        .prdata_o        (prdata_o),
        .pslverr_o       (pslverr_o),
        .wr_vld_i        (wr_vld_i),
        .wr_entry_i      (wr_entry_i),
        .wr_offset_i     (wr_offset_i),
        .wr_data_i       (wr_data_i),
        .wr_dest_valid_i (wr_dest_valid_i),
        .rd_entry_i      (rd_entry_i),
        .rd_offset_i     (rd_offset_i),
        .rd_data_o       (rd_data_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            fail_run($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rdata(input string name, input kv_data_t exp, input kv_data_t act);
        checks++;
        if (act !== exp) begin
            fail_run($sformatf("** Error %s prdata expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_slverr(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            fail_run($sformatf("** Error %s pslverr expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_port(input string name, input kv_data_t exp, input kv_data_t act);
        checks++;
        if (act !== exp) begin
            fail_run($sformatf("** Error %s rd_data expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 1103515245 + 12345;
        return lcg_state >> 16;
    endfunction

    // inputs always change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // penable stays high up to the edge that samples pready
    task automatic apb_transfer(input kv_addr_t addr, input logic write, input kv_data_t wdata,
                                output kv_data_t rdata, output logic slverr);
        int waits;
        waits = 0;
        paddr_i  = addr;
        pwrite_i = write;
        pwdata_i = wdata;
        psel_i   = 1'b1;
        next_cycle();
        penable_i = 1'b1;
        do begin
            next_cycle();
            waits++;
        end while (!pready_o && waits < 4);
        if (!pready_o) begin
            fail_run($sformatf("apb transfer to %h never got pready", addr));
        end
        rdata  = prdata_o;
        slverr = pslverr_o;
        next_cycle();
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic stage_write(input client_t cl, input kv_entry_t entry, input kv_offset_t off,
                               input kv_data_t data, input kv_mask_t mask);
        wr_vld_i[cl]        = 1'b1;
        wr_entry_i[cl]      = entry;
        wr_offset_i[cl]     = off;
        wr_data_i[cl]       = data;
        wr_dest_valid_i[cl] = mask;
    endtask

    task automatic commit_writes();
        next_cycle();
        wr_vld_i = '0;
    endtask

    task automatic port_read(input string name, input rd_client_t cl, input kv_entry_t entry,
                             input kv_offset_t off, input kv_data_t exp);
        rd_entry_i[cl]  = entry;
        rd_offset_i[cl] = off;
        #6;
        check_port(name, exp, rd_data_o[cl]);
        next_cycle();
    endtask

    initial begin
        int              fd;
        int              code;
        int              want;
        string           tok;
        string           name;
        string           line;
        logic [31:0]     a, b, c, d, e;
        logic [4:0][31:0] fld;
        kv_data_t        rdata;
        logic            slverr;

        rst_i           = 1'b1;
        paddr_i         = '0;
        psel_i          = 1'b0;
        penable_i       = 1'b0;
        pwrite_i        = 1'b0;
        pwdata_i        = '0;
        wr_vld_i        = '0;
        wr_entry_i      = '0;
        wr_offset_i     = '0;
        wr_data_i       = '0;
        wr_dest_valid_i = '0;
        rd_entry_i      = '0;
        rd_offset_i     = '0;

        fd = $fopen("kv_golden.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the golden file kv_golden.txt");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(line, fd);
            end else begin
                {a, b, c, d, e} = '0;
                want = 0;
                case (tok)
                    "W", "R": begin
                        want = 4;
                        code = $fscanf(fd, "%s %h %h %h", name, a, b, c);
                    end
                    "P": begin
                        want = 5;
                        code = $fscanf(fd, "%s %h %h %h %h", name, a, b, c, d);
                    end
                    "H", "C": begin
                        want = 6;
                        code = $fscanf(fd, "%s %h %h %h %h %h", name, a, b, c, d, e);
                    end
                    default:  fail_run($sformatf("unknown op %s in the golden file", tok));
                endcase
                if (code != want) begin
                    fail_run($sformatf("malformed golden line for op %s", tok));
                end
                op_q.push_back(tok);
                name_q.push_back(name);
                fld_q.push_back({e, d, c, b, a});
            end
        end
        $fclose(fd);
        cycle_limit = op_q.size() * 10 + 50;

        repeat (2) @(posedge clk);
        #2;
        rst_i = 1'b0;

        foreach (op_q[i]) begin
            fld = fld_q[i];
            // random idle gap between operations
            repeat (lcg_next() % 4) next_cycle();
            case (op_q[i])
                "W": begin
                    apb_transfer(kv_addr_t'(fld[0]), 1'b1, fld[1], rdata, slverr);
                    check_slverr(name_q[i], fld[2][0], slverr);
                end
                "R": begin
                    apb_transfer(kv_addr_t'(fld[0]), 1'b0, '0, rdata, slverr);
                    check_rdata(name_q[i], fld[1], rdata);
                    check_slverr(name_q[i], fld[2][0], slverr);
                end
                "H": begin
                    stage_write(client_t'(fld[0]), kv_entry_t'(fld[1]), kv_offset_t'(fld[2]),
                                fld[3], kv_mask_t'(fld[4]));
                    commit_writes();
                end
                "C": begin
                    // both clients hit the same dword in one cycle
                    stage_write(client_t'(0), kv_entry_t'(fld[0]), kv_offset_t'(fld[1]),
                                fld[2], kv_mask_t'(fld[4]));
                    stage_write(client_t'(1), kv_entry_t'(fld[0]), kv_offset_t'(fld[1]),
                                fld[3], kv_mask_t'(fld[4]));
                    commit_writes();
                end
                default: begin
                    port_read(name_q[i], rd_client_t'(fld[0]), kv_entry_t'(fld[1]),
                              kv_offset_t'(fld[2]), fld[3]);
                end
            endcase
        end

        if (checks == 0) begin
            fail_run("the golden file holds no checks");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- kv_top.sv
`timescale 1ns/100ps

module kv_top import kv_pkg::*; #(
    parameter int NUM_READ  = 2,
    parameter int NUM_WRITE = 2
) (
    input  logic                       clk,
    input  logic                       rst_i,

    // firmware apb port
    input  kv_addr_t                   paddr_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  kv_data_t                   pwdata_i,
    output logic                       pready_o,
    output kv_data_t                   prdata_o,
    output logic                       pslverr_o,

    // crypto engine write ports
    input  logic       [NUM_WRITE-1:0] wr_vld_i,
    input  kv_entry_t  [NUM_WRITE-1:0] wr_entry_i,
    input  kv_offset_t [NUM_WRITE-1:0] wr_offset_i,
    input  kv_data_t   [NUM_WRITE-1:0] wr_data_i,
    input  kv_mask_t   [NUM_WRITE-1:0] wr_dest_valid_i,

    // crypto engine read ports
    input  kv_entry_t  [NUM_READ-1:0]  rd_entry_i,
    input  kv_offset_t [NUM_READ-1:0]  rd_offset_i,
    output kv_data_t   [NUM_READ-1:0]  rd_data_o
);

    kv_data_t [KV_NUM_KEYS-1:0][KV_NUM_DWORDS-1:0] key_data;
    logic     [KV_NUM_KEYS-1:0]                  lock_use;
    kv_mask_t [KV_NUM_KEYS-1:0]                  dest_valid;

    kv_req_if req_bus ();

    kv_apb_decode u_decode (
        .clk       (clk),
        .rst_i     (rst_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .pready_o  (pready_o),
        .prdata_o  (prdata_o),
        .pslverr_o (pslverr_o),
        .req       (req_bus.dec)
    );

    kv_store #(
        .NUM_READ  (NUM_READ),
        .NUM_WRITE (NUM_WRITE)
    ) u_store (
        .clk             (clk),
        .rst_i           (rst_i),
        .req             (req_bus.store),
        .wr_vld_i        (wr_vld_i),
        .wr_entry_i      (wr_entry_i),
        .wr_offset_i     (wr_offset_i),
        .wr_data_i       (wr_data_i),
        .wr_dest_valid_i (wr_dest_valid_i),
        .key_data_o      (key_data),
        .lock_use_o      (lock_use),
        .dest_valid_o    (dest_valid)
    );

    kv_read_mux #(
        .NUM_READ (NUM_READ)
    ) u_read_mux (
        .key_data_i   (key_data),
        .lock_use_i   (lock_use),
        .dest_valid_i (dest_valid),
        .rd_entry_i   (rd_entry_i),
        .rd_offset_i  (rd_offset_i),
        .rd_data_o    (rd_data_o)
    );

endmodule

//--- src.f
kv_pkg.sv
kv_req_if.sv
kv_apb_decode.sv
kv_store.sv
kv_read_mux.sv
kv_top.sv
kv_tb.sv
